//--- common/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath widths
`define EXE_DATA_W   32
`define EXE_CMD_W    5
`define EXE_CC_W     4
`define EXE_FLAGS_W  5

// alu commands
`define EXE_ADD          5'h00
`define EXE_SUB          5'h01
`define EXE_AND          5'h02
`define EXE_OR           5'h03
`define EXE_XOR          5'h04
`define EXE_CMP          5'h05   // subtract, flags only

// branch commands
`define EXE_BRANCH_BUR   5'h10   // relative via register
`define EXE_BRANCH_BR    5'h11   // relative
`define EXE_BRANCH_B     5'h12   // absolute
`define EXE_BRANCH_INTB  5'h13   // interrupt branch
`define EXE_BRANCH_IDTS  5'h14   // interrupt return
`define EXE_BRANCH_HALT  5'h15

// condition codes
`define CC_AL    4'd0
`define CC_EQ    4'd1
`define CC_NEQ   4'd2
`define CC_MI    4'd3
`define CC_PL    4'd4
`define CC_EN    4'd5
`define CC_ON    4'd6
`define CC_OVF   4'd7
`define CC_UEO   4'd8
`define CC_UU    4'd9
`define CC_UO    4'd10
`define CC_UEU   4'd11
`define CC_SEO   4'd12
`define CC_SU    4'd13
`define CC_SO    4'd14
`define CC_SEU   4'd15

// bit positions in the flag word
`define FLAGS_ZF  0
`define FLAGS_PF  1
`define FLAGS_CF  2
`define FLAGS_OF  3
`define FLAGS_SF  4

`endif

//--- common/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

	// member order puts zf at bit 0 and sf at bit 4
	typedef struct packed {
		logic sf;   // result msb
		logic of;   // signed overflow
		logic cf;   // carry out, or no borrow on subtract
		logic pf;   // result is odd
		logic zf;   // result is zero
	} flags_t;

	// one instruction entering execute
	typedef struct packed {
		logic [`EXE_CMD_W-1:0]  cmd;
		logic [`EXE_CC_W-1:0]   cc;
		logic [`EXE_DATA_W-1:0] pc;
		logic [`EXE_DATA_W-1:0] src0;
		logic [`EXE_DATA_W-1:0] src1;
	} exec_req_t;

	typedef struct packed {
		logic [`EXE_DATA_W-1:0] result;
		flags_t                 flags;
		logic                   write_flags;   // set for the six alu commands
	} alu_out_t;

	typedef struct packed {
		logic [`EXE_DATA_W-1:0] addr;   // branch target
		logic                   jump;
		logic                   ib;
		logic                   idts;
		logic                   halt;
	} branch_out_t;

	// registered response of the stage
	typedef struct packed {
		logic [`EXE_DATA_W-1:0] alu;   // alu result, zero for branches
		branch_out_t            br;
	} exec_resp_t;

endpackage

//--- branch/branch_cond.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module branch_cond
	import exec_pkg::*;
(
	input  logic [`EXE_CC_W-1:0] cc,
	input  flags_t               flags,
	output logic                 taken
);

	logic zf;
	logic pf;
	logic cf;
	logic of;
	logic sf;
	logic sign_ne_ovf;   // signed less-than

	// pick the flag bits by position, matching the flag word layout
	assign zf = flags[`FLAGS_ZF];
	assign pf = flags[`FLAGS_PF];
	assign cf = flags[`FLAGS_CF];
	assign of = flags[`FLAGS_OF];
	assign sf = flags[`FLAGS_SF];

	assign sign_ne_ovf = sf ^ of;

	always_comb
	begin
		case (cc)
			`CC_AL:  taken = 1'b1;
			`CC_EQ:  taken = zf;
			`CC_NEQ: taken = !zf;
			`CC_MI:  taken = sf;
			`CC_PL:  taken = !sf;
			`CC_EN:  taken = !pf;           // even
			`CC_ON:  taken = pf;            // odd
			`CC_OVF: taken = of;
			// unsigned compares, cf means no borrow
			`CC_UEO: taken = cf;                  // a >= b
			`CC_UU:  taken = !cf;                 // a < b
			`CC_UO:  taken = cf && !zf;           // a > b
			`CC_UEU: taken = !cf || zf;           // a <= b
			// signed compares
			`CC_SEO: taken = !sign_ne_ovf;        // a >= b
			`CC_SU:  taken = sign_ne_ovf;         // a < b
			`CC_SO:  taken = !(sign_ne_ovf || zf);
			`CC_SEU: taken = sign_ne_ovf || zf;
			default: taken = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- branch/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module branch_unit
	import exec_pkg::*;
(
	input  logic [`EXE_CMD_W-1:0]  cmd,
	input  logic [`EXE_CC_W-1:0]   cc,
	input  logic [`EXE_DATA_W-1:0] pc,
	input  logic [`EXE_DATA_W-1:0] target,
	input  flags_t                 flags,
	output branch_out_t            out
);

	logic taken;       // condition result from stored flags
	logic is_branch;

	branch_cond u_cond (
		.cc    (cc),
		.flags (flags),
		.taken (taken)
	);

	function automatic logic [`EXE_DATA_W-1:0] branch_addr(
		input logic [`EXE_CMD_W-1:0]  f_cmd,
		input logic [`EXE_DATA_W-1:0] f_pc,
		input logic [`EXE_DATA_W-1:0] f_target
	);
		case (f_cmd)
			`EXE_BRANCH_BUR,
			`EXE_BRANCH_BR:   branch_addr = f_target + f_pc;
			`EXE_BRANCH_B:    branch_addr = f_target;
			`EXE_BRANCH_IDTS: branch_addr = f_pc + 32'd4;   // return past the trap
			default:          branch_addr = '0;             // intb, halt and non-branch
		endcase
	endfunction

	always_comb
	begin
		case (cmd)
			`EXE_BRANCH_BUR, `EXE_BRANCH_BR, `EXE_BRANCH_B,
			`EXE_BRANCH_INTB, `EXE_BRANCH_IDTS, `EXE_BRANCH_HALT:
				is_branch = 1'b1;
			default:
				is_branch = 1'b0;
		endcase
	end

	assign out.addr = branch_addr(cmd, pc, target);

	// interrupt entry and return jump unconditionally through their own strobes
	assign out.jump = is_branch && taken &&
		(cmd != `EXE_BRANCH_INTB) && (cmd != `EXE_BRANCH_IDTS);
	assign out.ib   = (cmd == `EXE_BRANCH_INTB);
	assign out.idts = (cmd == `EXE_BRANCH_IDTS);
	assign out.halt = (cmd == `EXE_BRANCH_HALT);

endmodule

`default_nettype wire

//--- verilog/flag_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module flag_alu
	import exec_pkg::*;
(
	input  logic [`EXE_CMD_W-1:0]  cmd,
	input  logic [`EXE_DATA_W-1:0] a,
	input  logic [`EXE_DATA_W-1:0] b,
	output alu_out_t               out
);

	localparam int MSB = `EXE_DATA_W - 1;

	logic [`EXE_DATA_W:0]   sum;     // carry out in the top bit
	logic [`EXE_DATA_W:0]   diff;    // a + ~b + 1
	logic [`EXE_DATA_W-1:0] value;   // operation result before cmp masking
	logic                   carry;
	logic                   ovf;
	logic                   is_alu;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

	always_comb
	begin
		value  = '0;
		carry  = 1'b0;
		ovf    = 1'b0;
		is_alu = 1'b1;
		case (cmd)
			`EXE_ADD:
			begin
				value = sum[MSB:0];
				carry = sum[`EXE_DATA_W];
				// same operand signs, result sign flipped
				ovf   = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			`EXE_SUB, `EXE_CMP:
			begin
				value = diff[MSB:0];
				carry = diff[`EXE_DATA_W];   // high when no borrow
				ovf   = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			`EXE_AND: value = a & b;
			`EXE_OR:  value = a | b;
			`EXE_XOR: value = a ^ b;
			default:  is_alu = 1'b0;   // branch or unknown command
		endcase
	end

	// compare keeps only its flags
	assign out.result = (cmd == `EXE_CMP) ? '0 : value;

	assign out.flags.zf = is_alu && (value == '0);
	assign out.flags.pf = value[0];
	assign out.flags.cf = carry;
	assign out.flags.of = ovf;
	assign out.flags.sf = value[MSB];

	assign out.write_flags = is_alu;

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module exec_stage
	import exec_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       in_valid,
	input  exec_req_t  req,
	output logic       out_valid,
	output exec_resp_t resp,
	output flags_t     flags
);

	alu_out_t    alu_out;
	branch_out_t br_out;

	// output register fields
	logic [`EXE_DATA_W-1:0] result_q;
	logic [`EXE_DATA_W-1:0] addr_q;
	logic                   jump_q;
	logic                   ib_q;
	logic                   idts_q;
	logic                   halt_q;

	flag_alu u_alu (
		.cmd (req.cmd),
		.a   (req.src0),
		.b   (req.src1),
		.out (alu_out)
	);

	// branches see the flags as left by the last completed alu command
	branch_unit u_branch (
		.cmd    (req.cmd),
		.cc     (req.cc),
		.pc     (req.pc),
		.target (req.src1),
		.flags  (flags),
		.out    (br_out)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			jump_q    <= 1'b0;
			ib_q      <= 1'b0;
			idts_q    <= 1'b0;
			halt_q    <= 1'b0;
			flags     <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			jump_q    <= in_valid && br_out.jump;
			ib_q      <= in_valid && br_out.ib;
			idts_q    <= in_valid && br_out.idts;
			halt_q    <= in_valid && br_out.halt;
			if (in_valid && alu_out.write_flags)
				flags <= alu_out.flags;   // architectural flags update
		end
	end

	// payload, zero on idle cycles
	always_ff @(posedge clock)
	begin
		result_q <= in_valid ? alu_out.result : '0;
		addr_q   <= in_valid ? br_out.addr : '0;
	end

	assign resp.alu     = result_q;
	assign resp.br.addr = addr_q;
	assign resp.br.jump = jump_q;
	assign resp.br.ib   = ib_q;
	assign resp.br.idts = idts_q;
	assign resp.br.halt = halt_q;

endmodule

`default_nettype wire

//--- tb/exec_stage_checker.sv
`timescale 1ns/1ps

module exec_stage_checker
	import exec_pkg::*;
(
	input logic       clock,
	input logic       reset,
	input logic       in_valid,
	input logic       out_valid,
	input exec_resp_t resp
);

	a_reset_clears_valid: assert property (@(posedge clock)
		reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// one cycle latency, no stall
	a_valid_follows_input: assert property (@(posedge clock) disable iff (reset)
		!$past(reset) |-> (out_valid == $past(in_valid)))
		else $error("out_valid does not follow in_valid of the previous cycle");

	a_strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
		$onehot0({resp.br.ib, resp.br.idts, resp.br.halt}))
		else $error("more than one of ib, idts and halt set");

	a_no_jump_on_interrupt: assert property (@(posedge clock) disable iff (reset)
		!(resp.br.jump && (resp.br.ib || resp.br.idts)))
		else $error("jump set together with ib or idts");

endmodule

bind exec_stage exec_stage_checker u_checker (
	.clock     (clock),
	.reset     (reset),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.resp      (resp)
);

//--- tb/exec_stage_tb.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_stage_tb
	import exec_pkg::*;
();

	typedef struct packed {
		logic       valid;
		exec_resp_t resp;
		flags_t     flags;
	} expect_t;

	localparam int ALU_RAND   = 16;
	localparam int N_CORNERS  = 14;
	localparam int ADDR_RAND  = 8;
	localparam int MIX_LEN    = 24;
	localparam int RESET_LEN  = 28;
	localparam int ALU_LEN    = 6 * ALU_RAND + N_CORNERS + 1;
	localparam int COND_LEN   = 32 * 17 + 1;
	localparam int ADDR_LEN   = 6 * ADDR_RAND + 1;
	localparam int HOLD_LEN   = 16 + MIX_LEN + 1;
	localparam int MAX_CYCLES = 2 * (RESET_LEN + ALU_LEN + COND_LEN + ADDR_LEN + HOLD_LEN);

	logic       clock;
	logic       reset;
	logic       in_valid;
	exec_req_t  req;
	logic       out_valid;
	exec_resp_t resp;
	flags_t     flags;

	logic [31:0] lfsr;
	flags_t      ref_flags;     // model of the architectural flags
	expect_t     pending;       // response due after the next edge
	logic        pending_set;
	int          errors;
	int          checks;
	int          cycles;
	int          skipped;

	logic [4:0] alu_cmds [6] = '{`EXE_ADD, `EXE_SUB, `EXE_AND, `EXE_OR, `EXE_XOR, `EXE_CMP};
	logic [4:0] br_cmds  [6] = '{`EXE_BRANCH_BUR, `EXE_BRANCH_BR, `EXE_BRANCH_B,
		`EXE_BRANCH_INTB, `EXE_BRANCH_IDTS, `EXE_BRANCH_HALT};

	// carry, borrow, overflow, zero and parity corners
	logic [4:0]  corner_cmd [N_CORNERS] = '{`EXE_ADD, `EXE_ADD, `EXE_ADD, `EXE_ADD,
		`EXE_SUB, `EXE_SUB, `EXE_SUB, `EXE_SUB, `EXE_CMP, `EXE_CMP, `EXE_AND, `EXE_OR,
		`EXE_XOR, `EXE_CMP};
	logic [31:0] corner_a [N_CORNERS] = '{32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0,
		32'h0, 32'h8000_0000, 32'h5, 32'h7FFF_FFFF, 32'h3, 32'h1, 32'hF0F0_F0F0, 32'h0,
		32'hAAAA_AAAA, 32'h8000_0000};
	logic [31:0] corner_b [N_CORNERS] = '{32'h1, 32'h1, 32'h8000_0000, 32'h0,
		32'h1, 32'h1, 32'h5, 32'hFFFF_FFFF, 32'h3, 32'h2, 32'h0F0F_0F0F, 32'h1,
		32'hAAAA_AAAB, 32'h7FFF_FFFF};

	exec_stage DUT (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.resp      (resp),
		.flags     (flags)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	// galois lfsr shifting right, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic alu_out_t alu_model(input logic [4:0] cmd, input logic [31:0] a,
		input logic [31:0] b);
		alu_out_t    o;
		logic [32:0] usum;
		logic [32:0] ext;   // sign extended, overflow when the top two bits differ
		logic [31:0] r;
		o = '0;
		o.write_flags = 1'b1;
		case (cmd)
			`EXE_ADD:
			begin
				usum = {1'b0, a} + {1'b0, b};
				ext  = {a[31], a} + {b[31], b};
				r    = a + b;
				o.flags.cf = usum[32];
				o.flags.of = ext[32] ^ ext[31];
			end
			`EXE_SUB, `EXE_CMP:
			begin
				ext = {a[31], a} - {b[31], b};
				r   = a - b;
				o.flags.cf = (a >= b);   // no borrow
				o.flags.of = ext[32] ^ ext[31];
			end
			`EXE_AND: r = a & b;
			`EXE_OR:  r = a | b;
			`EXE_XOR: r = a ^ b;
			default:
			begin
				r = '0;
				o.write_flags = 1'b0;
			end
		endcase
		if (o.write_flags)
		begin
			o.flags.zf = (r == 32'd0);
			o.flags.pf = r[0];
			o.flags.sf = r[31];
		end
		o.result = (cmd == `EXE_CMP) ? 32'd0 : r;
		return o;
	endfunction

	function automatic logic cond_model(input logic [3:0] cc, input flags_t f);
		case (cc)
			`CC_AL:  return 1'b1;
			`CC_EQ:  return f.zf;
			`CC_NEQ: return !f.zf;
			`CC_MI:  return f.sf;
			`CC_PL:  return !f.sf;
			`CC_EN:  return !f.pf;
			`CC_ON:  return f.pf;
			`CC_OVF: return f.of;
			`CC_UEO: return f.cf;
			`CC_UU:  return !f.cf;
			`CC_UO:  return f.cf && !f.zf;
			`CC_UEU: return !f.cf || f.zf;
			`CC_SEO: return f.sf == f.of;
			`CC_SU:  return f.sf != f.of;
			`CC_SO:  return (f.sf == f.of) && !f.zf;
			default: return (f.sf != f.of) || f.zf;   // seu
		endcase
	endfunction

	function automatic branch_out_t branch_model(input exec_req_t r, input flags_t f);
		branch_out_t o;
		logic        cond;
		o = '0;
		cond = cond_model(r.cc, f);
		case (r.cmd)
			`EXE_BRANCH_BUR, `EXE_BRANCH_BR:
			begin
				o.addr = r.src1 + r.pc;
				o.jump = cond;
			end
			`EXE_BRANCH_B:
			begin
				o.addr = r.src1;
				o.jump = cond;
			end
			`EXE_BRANCH_INTB: o.ib = 1'b1;
			`EXE_BRANCH_IDTS:
			begin
				o.addr = r.pc + 32'd4;
				o.idts = 1'b1;
			end
			`EXE_BRANCH_HALT:
			begin
				o.jump = cond;
				o.halt = 1'b1;
			end
			default: o = '0;
		endcase
		return o;
	endfunction

	// operands whose alu result leaves flag pattern t, zero when no result can
	function automatic logic flag_setup(input flags_t t, output logic [4:0] cmd,
		output logic [31:0] a, output logic [31:0] b);
		logic [31:0] r;
		cmd = `EXE_CMP;
		a   = '0;
		b   = '0;
		if (t.zf)
		begin
			// a zero result is even and positive, overflow into zero always carries
			if (t.pf || t.sf || (t.of && !t.cf))
				return 1'b0;
			if (!t.cf)
			begin
				cmd = `EXE_AND;
				a   = 32'h0F0F_0F0F;
				b   = 32'hF0F0_F0F0;
			end
			else if (t.of)
			begin
				cmd = `EXE_ADD;
				a   = 32'h8000_0000;
				b   = 32'h8000_0000;
			end
			else
			begin
				a = 32'h1234_5678;
				b = 32'h1234_5678;
			end
			return 1'b1;
		end
		if (t.of && (t.cf == t.sf))   // overflow leaves carry opposite to sign
			return 1'b0;
		r = {t.sf, 30'h0000_0080, t.pf};
		if (!t.of && t.cf)
			b = 32'h0;
		else if (!t.of)
			b = 32'hFFFF_FF00;
		else if (t.sf)
			b = 32'h8000_0000;
		else
			b = 32'h7FFF_FFFF;
		a = r + b;
		return 1'b1;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("FAIL at %0t ns: %s", $time, msg);
	endtask

	task automatic compare_output(input expect_t e);
		checks++;
		if (out_valid !== e.valid)
			report_mismatch($sformatf("out_valid %b, expected %b", out_valid, e.valid));
		if (resp !== e.resp)
			report_mismatch($sformatf("resp alu %h addr %h jump/ib/idts/halt %b, expected %h %h %b",
				resp.alu, resp.br.addr, {resp.br.jump, resp.br.ib, resp.br.idts, resp.br.halt},
				e.resp.alu, e.resp.br.addr,
				{e.resp.br.jump, e.resp.br.ib, e.resp.br.idts, e.resp.br.halt}));
		if (flags !== e.flags)
			report_mismatch($sformatf("flags %b, expected %b", flags, e.flags));
	endtask

	// one cycle, checks the response of the previous cycle
	task automatic step(input logic valid, input exec_req_t r);
		expect_t  e;
		alu_out_t a;
		@(posedge clock);
		in_valid <= valid;
		req      <= r;
		e = '0;
		e.valid = valid;
		if (valid)
		begin
			a = alu_model(r.cmd, r.src0, r.src1);
			e.resp.alu = a.result;
			e.resp.br  = branch_model(r, ref_flags);
			if (a.write_flags)
				ref_flags = a.flags;
		end
		e.flags = ref_flags;
		@(negedge clock);
		if (pending_set)
			compare_output(pending);
		pending     = e;
		pending_set = 1'b1;
	endtask

	task automatic issue(input logic [4:0] cmd, input logic [3:0] cc, input logic [31:0] pc,
		input logic [31:0] a, input logic [31:0] b);
		exec_req_t r;
		r.cmd  = cmd;
		r.cc   = cc;
		r.pc   = pc;
		r.src0 = a;
		r.src1 = b;
		step(1'b1, r);
	endtask

	task automatic idle_cycle();
		step(1'b0, '0);
	endtask

	// the last request stays valid, so only reset can clear the stage
	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		repeat (10) @(posedge clock);
		reset    <= 1'b0;
		in_valid <= 1'b0;
		@(negedge clock);
		pending_set = 1'b0;
		ref_flags   = '0;
		checks++;
		if (out_valid !== 1'b0)
			report_mismatch($sformatf("out_valid %b after reset", out_valid));
		if ({resp.br.jump, resp.br.ib, resp.br.idts, resp.br.halt} !== 4'b0000)
			report_mismatch("branch strobes not cleared by reset");
		if (flags !== 5'b00000)
			report_mismatch($sformatf("flags %b after reset", flags));
	endtask

	task automatic test_reset();
		apply_reset();
		issue(`EXE_ADD, `CC_AL, 32'h0, 32'h8000_0000, 32'h8000_0000);   // zf, cf, of
		issue(`EXE_BRANCH_HALT, `CC_AL, 32'h40, 32'h0, 32'h0);
		apply_reset();
	endtask

	task automatic test_alu();
		logic [3:0]  cc;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		for (int c = 0; c < 6; c++)
		begin
			repeat (ALU_RAND)
			begin
				cc = 4'(random_bits(4));
				pc = random_bits(32);
				a  = random_bits(32);
				b  = random_bits(32);
				issue(alu_cmds[c], cc, pc, a, b);
			end
		end
		for (int i = 0; i < N_CORNERS; i++)
			issue(corner_cmd[i], `CC_AL, 32'h0, corner_a[i], corner_b[i]);
		idle_cycle();
	endtask

	task automatic test_conditions();
		logic [4:0]  cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc;
		logic [31:0] src0;
		logic [31:0] tgt;
		alu_out_t    model;
		for (int p = 0; p < 32; p++)
		begin
			if (!flag_setup(flags_t'(p[4:0]), cmd, a, b))
			begin
				skipped++;
				continue;
			end
			model = alu_model(cmd, a, b);
			if (model.flags !== flags_t'(p[4:0]))
				report_mismatch($sformatf("setup for pattern %b gives %b", p[4:0], model.flags));
			issue(cmd, `CC_AL, 32'h0, a, b);
			for (int cc = 0; cc < 16; cc++)
			begin
				pc   = random_bits(32);
				src0 = random_bits(32);
				tgt  = random_bits(32);
				issue(`EXE_BRANCH_BR, cc[3:0], pc, src0, tgt);
			end
		end
		idle_cycle();
		$display("note: %0d of 32 flag patterns cannot come from an alu result", skipped);
	endtask

	task automatic test_addresses();
		logic [3:0]  cc;
		logic [31:0] pc;
		logic [31:0] src0;
		logic [31:0] tgt;
		for (int c = 0; c < 6; c++)
		begin
			repeat (ADDR_RAND)
			begin
				cc   = 4'(random_bits(4));
				pc   = random_bits(32);
				src0 = random_bits(32);
				tgt  = random_bits(32);
				issue(br_cmds[c], cc, pc, src0, tgt);
			end
		end
		idle_cycle();
	endtask

	task automatic test_flag_hold();
		exec_req_t r;
		int        sel;
		logic      valid;
		issue(`EXE_CMP, `CC_AL, 32'h0, 32'h5, 32'h5);
		issue(`EXE_BRANCH_BR, `CC_EQ, 32'h100, 32'h0, 32'h20);   // sees the new zf
		issue(`EXE_BRANCH_B, `CC_NEQ, 32'h104, 32'h0, 32'h300);
		idle_cycle();
		issue(`EXE_BRANCH_HALT, `CC_AL, 32'h108, 32'h0, 32'h0);
		issue(5'h1F, `CC_AL, 32'h10C, 32'h1, 32'h2);             // not an alu command
		issue(`EXE_BRANCH_BR, `CC_EQ, 32'h110, 32'h0, 32'h8);
		issue(`EXE_SUB, `CC_AL, 32'h0, 32'h1, 32'h2);
		issue(`EXE_BRANCH_BUR, `CC_UU, 32'h114, 32'h0, 32'hFFFF_FFF0);
		issue(`EXE_BRANCH_INTB, `CC_AL, 32'h118, 32'h0, 32'h0);
		idle_cycle();
		idle_cycle();
		issue(`EXE_BRANCH_IDTS, `CC_AL, 32'h11C, 32'h0, 32'h0);
		issue(`EXE_BRANCH_BR, `CC_MI, 32'h120, 32'h0, 32'h4);
		issue(`EXE_XOR, `CC_AL, 32'h0, 32'h1234_5678, 32'h1234_5678);
		issue(`EXE_BRANCH_B, `CC_EQ, 32'h124, 32'h0, 32'h800);
		for (int i = 0; i < MIX_LEN; i++)
		begin
			sel = random_bits(4) % 13;
			if (sel < 6)
				r.cmd = alu_cmds[sel];
			else if (sel < 12)
				r.cmd = br_cmds[sel - 6];
			else
				r.cmd = 5'h1F;
			r.cc   = 4'(random_bits(4));
			r.pc   = random_bits(32);
			r.src0 = random_bits(32);
			r.src1 = random_bits(32);
			valid  = (random_bits(2) != 32'd0);   // idle cycles keep a live request
			step(valid, r);
		end
		idle_cycle();
	endtask

	initial
	begin
		reset       = 1'b1;
		in_valid    = 1'b0;
		req         = '0;
		lfsr        = 32'd74;
		ref_flags   = '0;
		pending     = '0;
		pending_set = 1'b0;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		skipped     = 0;
		test_reset();
		test_alu();
		test_conditions();
		test_addresses();
		test_flag_hold();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+common
common/exec_pkg.sv
branch/branch_cond.sv
branch/branch_unit.sv
verilog/flag_alu.sv
verilog/exec_stage.sv
tb/exec_stage_checker.sv
tb/exec_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the exec stage testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module exec_stage_tb -f all.f -o exec_stage_sim

# the log decides the result, so a stopped run still reaches the check
./obj_dir/exec_stage_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "all tests passed" "$LOG"; then
	echo "simulation PASSED"
else
	echo "simulation FAILED"
	exit 1
fi
